// File: hdl/dispatch_pkg.sv
package dispatch_pkg;

    // Physical register file
    localparam int PREG_WIDTH = 6;
    localparam int NUM_PREGS = 1 << PREG_WIDTH;  // 64 busy bits

    localparam int ROB_ID_WIDTH = 6;

    // Bundle shape
    localparam int DISPATCH_WIDTH = 2;  // Micro-ops per bundle, also alloc ports
    localparam int NUM_READ_PORTS = 2 * DISPATCH_WIDTH;  // rs1 and rs2 per slot
    localparam int NUM_FREE_PORTS = 2;  // Integer and memory writeback
    localparam int NUM_WALK_PORTS = 2;

    // ROB recovery state as seen by dispatch
    typedef enum logic [1:0] {
        ROB_IDLE     = 2'b00,
        ROB_ROLLBACK = 2'b01,
        ROB_WALK     = 2'b10
    } rob_state_e;

    // Renamed micro-op from the rename stage
    typedef struct packed {
        logic                    valid;
        logic [PREG_WIDTH-1:0]   rs1;
        logic [PREG_WIDTH-1:0]   rs2;
        logic [PREG_WIDTH-1:0]   rd;
        logic                    rd_en;  // Writes a destination
        logic [ROB_ID_WIDTH-1:0] robid;
    } dispatch_uop_t;

    // Micro-op on its way to execute, valid travels on its own wire
    typedef struct packed {
        logic [PREG_WIDTH-1:0]   rs1;
        logic [PREG_WIDTH-1:0]   rs2;
        logic [PREG_WIDTH-1:0]   rd;
        logic                    rd_en;
        logic [ROB_ID_WIDTH-1:0] robid;
    } issue_uop_t;

    // Writeback free, also reused as an alloc port
    typedef struct packed {
        logic                  en;
        logic [PREG_WIDTH-1:0] preg;
    } free_port_t;

    // One entry reported by the ROB walk
    typedef struct packed {
        logic                  valid;
        logic                  complete;  // Already written back, stays free
        logic [PREG_WIDTH-1:0] prd;
    } walk_port_t;

endpackage

// File: hdl/busy_table.sv
`timescale 1ns/1ps

module busy_table (
    input  logic clock,
    input  logic reset,
    input  logic flush,
    input  dispatch_pkg::free_port_t [dispatch_pkg::DISPATCH_WIDTH-1:0] alloc,
    input  dispatch_pkg::free_port_t [dispatch_pkg::NUM_FREE_PORTS-1:0] free,
    input  dispatch_pkg::walk_port_t [dispatch_pkg::NUM_WALK_PORTS-1:0] walk,
    input  logic [dispatch_pkg::NUM_READ_PORTS-1:0][dispatch_pkg::PREG_WIDTH-1:0] rd_addr,
    output logic [dispatch_pkg::NUM_READ_PORTS-1:0] rd_busy
);

    import dispatch_pkg::*;

    logic [NUM_PREGS-1:0] busy_q;
    logic [NUM_PREGS-1:0] busy_next;

    // Later loops win on the same bit: alloc, then free, then walk
    always_comb begin
        busy_next = busy_q;
        for (int a = 0; a < DISPATCH_WIDTH; a++) begin
            if (alloc[a].en) begin
                busy_next[alloc[a].preg] = 1'b1;
            end
        end
        for (int f = 0; f < NUM_FREE_PORTS; f++) begin
            if (free[f].en) begin
                busy_next[free[f].preg] = 1'b0;
            end
        end
        // Walk re-marks destinations not yet written back
        for (int w = 0; w < NUM_WALK_PORTS; w++) begin
            if (walk[w].valid && !walk[w].complete) begin
                busy_next[walk[w].prd] = 1'b1;
            end
        end
    end

    // Rollback wipes the whole table, ahead of alloc and walk
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_next;
        end
    end

    // Bypassed reads
    // Same-cycle alloc beats same-cycle free, which beats the stored bit
    always_comb begin
        for (int r = 0; r < NUM_READ_PORTS; r++) begin
            rd_busy[r] = busy_q[rd_addr[r]];
            for (int f = 0; f < NUM_FREE_PORTS; f++) begin
                if (free[f].en && (free[f].preg == rd_addr[r])) begin
                    rd_busy[r] = 1'b0;
                end
            end
            for (int a = 0; a < DISPATCH_WIDTH; a++) begin
                if (alloc[a].en && (alloc[a].preg == rd_addr[r])) begin
                    rd_busy[r] = 1'b1;  // Covers slot 1 reading the rd of slot 0
                end
            end
        end
    end

endmodule

// File: hdl/dispatch_ctrl.sv
`timescale 1ns/1ps

module dispatch_ctrl #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic clock,
    input  logic reset,
    input  dispatch_pkg::dispatch_uop_t [dispatch_pkg::DISPATCH_WIDTH-1:0] in_bundle,
    input  logic in_valid,
    output logic in_ready,
    input  dispatch_pkg::rob_state_e rob_state,
    input  logic [NUM_ENTRIES-1:0] entry_valid,
    output dispatch_pkg::free_port_t [dispatch_pkg::DISPATCH_WIDTH-1:0] alloc,
    output logic [dispatch_pkg::NUM_READ_PORTS-1:0][dispatch_pkg::PREG_WIDTH-1:0] rd_addr,
    output logic [NUM_ENTRIES-1:0] entry_load,
    output logic [NUM_ENTRIES-1:0] load_slot,  // Set where the entry takes slot 1
    output dispatch_pkg::dispatch_uop_t [NUM_ENTRIES-1:0] load_uop,
    output logic flush
);

    import dispatch_pkg::*;

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic             rob_idle;
    logic             fire;
    logic             first_found;
    logic             second_found;
    logic [IDX_W-1:0] first_idx;
    logic [IDX_W-1:0] second_idx;
    logic [IDX_W-1:0] slot1_idx;

    always_comb begin
        rob_idle = 1'b0;
        flush    = 1'b0;
        case (rob_state)
            ROB_IDLE:     rob_idle = 1'b1;
            ROB_ROLLBACK: flush = 1'b1;
            ROB_WALK:     rob_idle = 1'b0;  // Stall while the walk re-marks
            default:      rob_idle = 1'b0;
        endcase
    end

    // Two lowest free entries
    always_comb begin
        first_found  = 1'b0;
        second_found = 1'b0;
        first_idx    = '0;
        second_idx   = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!entry_valid[i]) begin
                if (!first_found) begin
                    first_idx   = IDX_W'(i);
                    first_found = 1'b1;
                end else if (!second_found) begin
                    second_idx   = IDX_W'(i);
                    second_found = 1'b1;
                end
            end
        end
    end

    // Whole bundle needs room, whatever its slot valids say
    assign in_ready = !reset && rob_idle && second_found;
    assign fire     = in_valid && in_ready;

    // Slot 1 moves down when slot 0 is empty
    assign slot1_idx = in_bundle[0].valid ? second_idx : first_idx;

    always_comb begin
        entry_load = '0;
        load_slot  = '0;
        load_uop   = '0;
        if (fire && in_bundle[0].valid) begin
            entry_load[first_idx] = 1'b1;
            load_uop[first_idx]   = in_bundle[0];
        end
        if (fire && in_bundle[1].valid) begin
            entry_load[slot1_idx] = 1'b1;
            load_slot[slot1_idx]  = 1'b1;
            load_uop[slot1_idx]   = in_bundle[1];
        end
    end

    // Busy table ports
    always_comb begin
        for (int s = 0; s < DISPATCH_WIDTH; s++) begin
            alloc[s].en       = fire && in_bundle[s].valid && in_bundle[s].rd_en;
            alloc[s].preg     = in_bundle[s].rd;
            rd_addr[2 * s]     = in_bundle[s].rs1;
            rd_addr[2 * s + 1] = in_bundle[s].rs2;
        end
    end

endmodule

// File: hdl/rs_entry.sv
`timescale 1ns/1ps

module rs_entry (
    input  logic clock,
    input  logic reset,
    input  logic flush,
    input  logic load,
    input  dispatch_pkg::dispatch_uop_t load_uop,
    input  logic load_rs1_busy,
    input  logic load_rs2_busy,
    input  dispatch_pkg::free_port_t [dispatch_pkg::NUM_FREE_PORTS-1:0] free,
    input  logic grant,
    output logic valid,
    output logic ready,
    output dispatch_pkg::issue_uop_t uop
);

    import dispatch_pkg::*;

    logic       valid_q;
    logic       rs1_busy_q;
    logic       rs2_busy_q;
    logic       rs1_wake;
    logic       rs2_wake;
    issue_uop_t uop_q;

    // Writeback snoop on both sources
    always_comb begin
        rs1_wake = 1'b0;
        rs2_wake = 1'b0;
        for (int f = 0; f < NUM_FREE_PORTS; f++) begin
            if (free[f].en && (free[f].preg == uop_q.rs1)) begin
                rs1_wake = 1'b1;
            end
            if (free[f].en && (free[f].preg == uop_q.rs2)) begin
                rs2_wake = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= load_uop.valid;
        end else if (grant) begin
            valid_q <= 1'b0;  // Left on the issue port
        end
    end

    // Payload and flags, only looked at while valid
    always_ff @(posedge clock) begin
        if (load) begin
            uop_q.rs1   <= load_uop.rs1;
            uop_q.rs2   <= load_uop.rs2;
            uop_q.rd    <= load_uop.rd;
            uop_q.rd_en <= load_uop.rd_en;
            uop_q.robid <= load_uop.robid;
            rs1_busy_q  <= load_rs1_busy;  // Already bypassed by the table
            rs2_busy_q  <= load_rs2_busy;
        end else begin
            if (rs1_wake) begin
                rs1_busy_q <= 1'b0;
            end
            if (rs2_wake) begin
                rs2_busy_q <= 1'b0;
            end
        end
    end

    assign valid = valid_q;
    assign ready = valid_q && !rs1_busy_q && !rs2_busy_q;
    assign uop   = uop_q;

endmodule

// File: hdl/issue_select.sv
`timescale 1ns/1ps

module issue_select #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic [NUM_ENTRIES-1:0] entry_ready,
    input  dispatch_pkg::issue_uop_t [NUM_ENTRIES-1:0] entry_uop,
    input  logic issue_ready,
    output logic [NUM_ENTRIES-1:0] grant,
    output logic issue_valid,
    output dispatch_pkg::issue_uop_t issue_uop
);

    import dispatch_pkg::*;

    logic                   found;
    logic                   hold_q;
    logic [NUM_ENTRIES-1:0] held_q;
    logic [NUM_ENTRIES-1:0] lowest_ready;
    logic [NUM_ENTRIES-1:0] pick;

    // Priority encoder, index 0 first
    always_comb begin
        found        = 1'b0;
        lowest_ready = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entry_ready[i] && !found) begin
                lowest_ready[i] = 1'b1;
                found           = 1'b1;
            end
        end
    end

    // A stalled pick stays put even if a lower entry wakes up
    assign pick = (hold_q && |(held_q & entry_ready)) ? held_q : lowest_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            hold_q <= 1'b0;
        end else begin
            hold_q <= issue_valid && !issue_ready;
        end
    end

    always_ff @(posedge clock) begin
        held_q <= pick;
    end

    always_comb begin
        issue_uop = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (pick[i]) begin
                issue_uop = entry_uop[i];
            end
        end
    end

    assign issue_valid = |pick;
    assign grant       = pick & {NUM_ENTRIES{issue_ready}};

endmodule

// File: hdl/dispatch_scoreboard.sv
`timescale 1ns/1ps

module dispatch_scoreboard #(
    parameter int NUM_ENTRIES = 4
) (
    input  logic clock,
    input  logic reset,
    input  dispatch_pkg::dispatch_uop_t [dispatch_pkg::DISPATCH_WIDTH-1:0] in_bundle,
    input  logic in_valid,
    output logic in_ready,
    input  dispatch_pkg::free_port_t [dispatch_pkg::NUM_FREE_PORTS-1:0] wb_free,
    input  dispatch_pkg::rob_state_e rob_state,
    input  dispatch_pkg::walk_port_t [dispatch_pkg::NUM_WALK_PORTS-1:0] walk,
    output dispatch_pkg::issue_uop_t issue_uop,
    output logic issue_valid,
    input  logic issue_ready
);

    import dispatch_pkg::*;

    logic                                        flush;
    free_port_t [DISPATCH_WIDTH-1:0]             alloc;
    logic [NUM_READ_PORTS-1:0][PREG_WIDTH-1:0]   rd_addr;
    logic [NUM_READ_PORTS-1:0]                   rd_busy;
    logic [NUM_ENTRIES-1:0]                      entry_load;
    logic [NUM_ENTRIES-1:0]                      load_slot;
    dispatch_uop_t [NUM_ENTRIES-1:0]             load_uop;
    logic [NUM_ENTRIES-1:0]                      entry_valid;
    logic [NUM_ENTRIES-1:0]                      entry_ready;
    issue_uop_t [NUM_ENTRIES-1:0]                entry_uop;
    logic [NUM_ENTRIES-1:0]                      grant;

    dispatch_ctrl #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_ctrl (
        .clock       (clock),
        .reset       (reset),
        .in_bundle   (in_bundle),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .rob_state   (rob_state),
        .entry_valid (entry_valid),
        .alloc       (alloc),
        .rd_addr     (rd_addr),
        .entry_load  (entry_load),
        .load_slot   (load_slot),
        .load_uop    (load_uop),
        .flush       (flush)
    );

    busy_table i_busy_table (
        .clock   (clock),
        .reset   (reset),
        .flush   (flush),
        .alloc   (alloc),
        .free    (wb_free),
        .walk    (walk),
        .rd_addr (rd_addr),
        .rd_busy (rd_busy)
    );

    // Read ports 0/1 belong to slot 0, ports 2/3 to slot 1
    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
        rs_entry i_entry (
            .clock         (clock),
            .reset         (reset),
            .flush         (flush),
            .load          (entry_load[i]),
            .load_uop      (load_uop[i]),
            .load_rs1_busy (load_slot[i] ? rd_busy[2] : rd_busy[0]),
            .load_rs2_busy (load_slot[i] ? rd_busy[3] : rd_busy[1]),
            .free          (wb_free),
            .grant         (grant[i]),
            .valid         (entry_valid[i]),
            .ready         (entry_ready[i]),
            .uop           (entry_uop[i])
        );
    end

    issue_select #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_select (
        .clock       (clock),
        .reset       (reset),
        .entry_ready (entry_ready),
        .entry_uop   (entry_uop),
        .issue_ready (issue_ready),
        .grant       (grant),
        .issue_valid (issue_valid),
        .issue_uop   (issue_uop)
    );

endmodule

// File: testbench/dispatch_scoreboard_props.sv
`timescale 1ns/1ps

module dispatch_scoreboard_props #(
    parameter int NUM_ENTRIES = 4
) (
    input logic                     clock,
    input logic                     reset,
    input dispatch_pkg::rob_state_e rob_state,
    input logic                     in_ready,
    input logic                     issue_valid,
    input logic                     issue_ready,
    input dispatch_pkg::issue_uop_t issue_uop,
    input logic [NUM_ENTRIES-1:0]   grant
);

    import dispatch_pkg::*;

    int fail_count = 0;  // Failed assertions so far

    // Stalled issue keeps its micro-op, a rollback may still empty the station
    a_issue_hold: assert property (@(posedge clock) disable iff (reset)
        issue_valid && !issue_ready && rob_state != ROB_ROLLBACK
        |=> issue_valid && $stable(issue_uop))
        else begin
            $error("issue_uop changed while the issue port was stalled");
            fail_count++;
        end

    a_rollback_empty: assert property (@(posedge clock) disable iff (reset)
        rob_state == ROB_ROLLBACK |=> !issue_valid)
        else begin
            $error("issue_valid high right after a rollback cycle");
            fail_count++;
        end

    // No dispatch during rollback or walk
    a_stall_recovery: assert property (@(posedge clock) disable iff (reset)
        rob_state != ROB_IDLE |-> !in_ready)
        else begin
            $error("in_ready high while the ROB is not idle");
            fail_count++;
        end

    a_grant_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(grant))
        else begin
            $error("more than one grant bit set");
            fail_count++;
        end

endmodule

// File: testbench/tb_dispatch_scoreboard.sv
`timescale 1ns/1ps

module tb_dispatch_scoreboard;

    import dispatch_pkg::*;

    localparam int NE         = 4;
    localparam int MAX_CYCLES = 2000;  // Directed sequence needs about 250

    logic                               clock;
    logic                               reset;
    dispatch_uop_t [DISPATCH_WIDTH-1:0] in_bundle;
    logic                               in_valid;
    logic                               in_ready;
    free_port_t [NUM_FREE_PORTS-1:0]    wb_free;
    rob_state_e                         rob_state;
    walk_port_t [NUM_WALK_PORTS-1:0]    walk;
    issue_uop_t                         issue_uop;
    logic                               issue_valid;
    logic                               issue_ready;

    // Reference model of busy bits and station slots
    logic [NUM_PREGS-1:0]    busy_m;
    issue_uop_t              slot_u [NE];
    logic [NE-1:0]           slot_v;
    logic [NE-1:0]           slot_b1;
    logic [NE-1:0]           slot_b2;
    int                      held_m;  // Slot stuck on a stalled issue port, or -1
    int                      cycle_count = 0;
    logic [ROB_ID_WIDTH-1:0] robid;
    logic [PREG_WIDTH-1:0]   src [4];  // Never allocated, so never busy
    logic [PREG_WIDTH-1:0]   dst [4];

    dispatch_scoreboard #(.NUM_ENTRIES(NE)) i_dut (.*);

    bind dispatch_scoreboard dispatch_scoreboard_props #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_props (.*);

    always #50 clock = ~clock;

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("Error at %0t: %s expected %h, actual %h",
                               $time, name, expected, actual));
        end
    endtask

    function automatic logic slot_ready(int i);
        return slot_v[i] && !slot_b1[i] && !slot_b2[i];
    endfunction

    // Lowest ready slot, except that a stalled pick stays
    function automatic int pick_slot();
        int p;
        p = -1;
        for (int i = NE - 1; i >= 0; i--) begin
            if (slot_ready(i)) p = i;
        end
        if (held_m >= 0 && slot_ready(held_m)) p = held_m;
        return p;
    endfunction

    function automatic logic exp_in_ready();
        return rob_state == ROB_IDLE && $countones(~slot_v) >= 2;
    endfunction

    // Same-cycle alloc gives busy, else same-cycle free gives not busy
    function automatic logic src_busy(logic [PREG_WIDTH-1:0] p);
        logic b;
        b = busy_m[p];
        for (int f = 0; f < NUM_FREE_PORTS; f++) begin
            if (wb_free[f].en && wb_free[f].preg == p) b = 1'b0;
        end
        for (int a = 0; a < DISPATCH_WIDTH; a++) begin
            if (in_bundle[a].valid && in_bundle[a].rd_en && in_bundle[a].rd == p) b = 1'b1;
        end
        return b;
    endfunction

    task automatic load_slot(int i, dispatch_uop_t u);
        slot_v[i]  = 1'b1;
        slot_u[i]  = '{rs1: u.rs1, rs2: u.rs2, rd: u.rd, rd_en: u.rd_en, robid: u.robid};
        slot_b1[i] = src_busy(u.rs1);
        slot_b2[i] = src_busy(u.rs2);
    endtask

    always @(posedge clock) begin : model_update
        int   p;
        int   f0;
        int   f1;
        logic fire;
        if (reset) begin
            busy_m = '0;
            slot_v = '0;
            held_m = -1;
        end else begin
            p    = pick_slot();
            fire = in_valid && exp_in_ready();
            f0   = -1;
            f1   = -1;
            for (int i = NE - 1; i >= 0; i--) begin
                if (!slot_v[i]) begin
                    f1 = f0;
                    f0 = i;
                end
            end
            for (int i = 0; i < NE; i++) begin  // Writeback wakeup
                for (int f = 0; f < NUM_FREE_PORTS; f++) begin
                    if (wb_free[f].en && wb_free[f].preg == slot_u[i].rs1) slot_b1[i] = 1'b0;
                    if (wb_free[f].en && wb_free[f].preg == slot_u[i].rs2) slot_b2[i] = 1'b0;
                end
            end
            if (p >= 0 && issue_ready) slot_v[p] = 1'b0;
            held_m = (p >= 0 && !issue_ready) ? p : -1;
            if (fire && in_bundle[0].valid) load_slot(f0, in_bundle[0]);
            if (fire && in_bundle[1].valid) begin
                load_slot(in_bundle[0].valid ? f1 : f0, in_bundle[1]);
            end
            for (int a = 0; a < DISPATCH_WIDTH; a++) begin
                if (fire && in_bundle[a].valid && in_bundle[a].rd_en) begin
                    busy_m[in_bundle[a].rd] = 1'b1;
                end
            end
            for (int f = 0; f < NUM_FREE_PORTS; f++) begin
                if (wb_free[f].en) busy_m[wb_free[f].preg] = 1'b0;
            end
            for (int w = 0; w < NUM_WALK_PORTS; w++) begin
                if (walk[w].valid && !walk[w].complete) busy_m[walk[w].prd] = 1'b1;
            end
            if (rob_state == ROB_ROLLBACK) begin
                busy_m = '0;
                slot_v = '0;
            end
        end
    end

    always @(negedge clock) begin : output_check
        int p;
        p = pick_slot();
        if (!reset) begin
            if (i_dut.i_props.fail_count != 0) fail_run("A concurrent assertion failed");
            check_value("in_ready", exp_in_ready(), in_ready);
            check_value("issue_valid", p >= 0, issue_valid);
            if (p >= 0) check_value("issue_uop", slot_u[p], issue_uop);
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) fail_run("Timeout: the run did not finish in time");
    end

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    function automatic dispatch_uop_t make_uop(logic [5:0] rs1, logic [5:0] rs2, logic [5:0] rd);
        return '{valid: 1'b1, rs1: rs1, rs2: rs2, rd: rd, rd_en: 1'b1, robid: '0};
    endfunction

    // Frees set up by the caller are dropped once the bundle is taken
    task automatic send(dispatch_uop_t u0, dispatch_uop_t u1);
        logic ok;
        in_bundle          = {u1, u0};
        in_bundle[0].robid = robid;
        in_bundle[1].robid = robid + 1'b1;
        robid              = robid + 2'd2;
        in_valid           = 1'b1;
        do begin
            @(negedge clock);
            ok = in_ready;
            step();
        end while (!ok);
        in_valid = 1'b0;
        wb_free  = '0;
    endtask

    task automatic free_one(int port, logic [5:0] preg);
        wb_free[port] = '{en: 1'b1, preg: preg};
        step();
        wb_free = '0;
    endtask

    task automatic free_all();
        for (int p = 0; p < NUM_PREGS; p += 2) begin
            wb_free[0] = '{en: 1'b1, preg: PREG_WIDTH'(p)};
            wb_free[1] = '{en: 1'b1, preg: PREG_WIDTH'(p + 1)};
            step();
        end
        wb_free = '0;
    endtask

    task automatic wait_empty();
        while (slot_v != '0) step();
    endtask

    initial begin
        void'($urandom(32'h48a0_7123));
        clock       = 1'b0;
        reset       = 1'b1;
        in_bundle   = '0;
        in_valid    = 1'b0;
        wb_free     = '0;
        rob_state   = ROB_IDLE;
        walk        = '0;
        issue_ready = 1'b1;
        robid       = '0;
        for (int i = 0; i < 4; i++) begin  // Distinct registers from separate ranges
            src[i] = PREG_WIDTH'(8 * i + $urandom_range(7, 0));
            dst[i] = PREG_WIDTH'(32 + 8 * i + $urandom_range(7, 0));
        end
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        step();
        // Independent pair
        send(make_uop(src[0], src[1], dst[0]), make_uop(src[2], src[3], dst[1]));
        wait_empty();
        free_all();
        // Slot 1 depends on slot 0
        send(make_uop(src[0], src[1], dst[2]), make_uop(dst[2], src[3], dst[3]));
        repeat (3) step();
        free_one(0, dst[2]);
        wait_empty();
        free_all();
        // Wakeup, the memory free lands with the dispatch
        send(make_uop(src[0], src[1], dst[0]), make_uop(src[2], src[3], dst[1]));
        wb_free[1] = '{en: 1'b1, preg: dst[0]};
        send(make_uop(dst[0], src[1], dst[2]), make_uop(src[2], dst[1], dst[3]));
        repeat (2) step();
        free_one(0, dst[1]);
        wait_empty();
        free_all();
        // Stalled issue port fills the station, dst[2] stays busy
        send(make_uop(src[0], src[1], dst[2]), make_uop(src[2], src[3], dst[3]));
        wait_empty();
        issue_ready = 1'b0;
        send(make_uop(dst[2], src[1], dst[0]), make_uop(src[2], src[3], dst[1]));
        send(make_uop(src[1], src[2], dst[0]), make_uop(src[3], src[0], dst[1]));
        step();
        free_one(0, dst[2]);  // Lower entry wakes while the pick is held
        repeat (2) step();
        issue_ready = 1'b1;
        wait_empty();
        free_all();
        // Rollback, then walk re-marks dst[0] only
        send(make_uop(src[0], src[1], dst[0]), make_uop(src[2], src[3], dst[1]));
        send(make_uop(dst[0], src[1], dst[2]), make_uop(dst[1], src[3], dst[3]));
        rob_state = ROB_ROLLBACK;
        step();
        rob_state = ROB_WALK;
        walk[0]   = '{valid: 1'b1, complete: 1'b0, prd: dst[0]};
        walk[1]   = '{valid: 1'b1, complete: 1'b1, prd: dst[1]};
        step();
        walk = '0;
        step();
        rob_state = ROB_IDLE;
        send(make_uop(dst[0], src[0], dst[2]), make_uop(dst[1], src[1], dst[3]));
        repeat (3) step();
        free_one(1, dst[0]);
        wait_empty();
        free_all();
        if (i_dut.i_props.fail_count == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run("A concurrent assertion failed");
        end
    end

endmodule

// File: filelist.f
hdl/dispatch_pkg.sv
hdl/busy_table.sv
hdl/dispatch_ctrl.sv
hdl/rs_entry.sv
hdl/issue_select.sv
hdl/dispatch_scoreboard.sv
testbench/dispatch_scoreboard_props.sv
testbench/tb_dispatch_scoreboard.sv
